// File: source/game_mem_defines.svh
// game memory parameters
`ifndef GAME_MEM_DEFINES_SVH
`define GAME_MEM_DEFINES_SVH

// rom word address bits, 4k words
`define GM_AW          12

// rom data bus width
`define GM_DW          16

// store read latency in clk96 cycles, sdram-like
`define GM_MEM_LAT     4

// reset synchroniser length
`define GM_RST_STAGES  3

// words in the rom store, must match GM_AW
`define GM_DEPTH       4096

`endif

// File: source/game_mem_pkg.sv
// game memory bus types
`include "game_mem_defines.svh"

package game_mem_pkg;

    // who owns a bus transfer
    typedef enum logic [1:0] {
        ID_NONE = 2'd0,  // nobody, idle bus
        ID_CPU  = 2'd1,
        ID_VID  = 2'd2
    } port_id_e;

    // read request from a slot towards the store
    typedef struct packed {
        logic              valid;
        logic [`GM_AW-1:0] addr;   // word address
        port_id_e          id;     // echoed back in the response
    } rom_req_t;

    // read response, broadcast to every slot
    typedef struct packed {
        logic              valid;  // one cycle strobe
        port_id_e          id;
        logic [`GM_DW-1:0] data;
    } rom_rsp_t;

    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,  // free, may grant
        ARB_WAIT = 2'd1,  // read in flight
        ARB_LOAD = 2'd2   // loader owns the bus
    } arb_state_e;

    typedef enum logic [1:0] {
        SLOT_IDLE = 2'd0,
        SLOT_REQ  = 2'd1,  // asking the arbiter
        SLOT_WAIT = 2'd2   // granted, data on its way
    } slot_state_e;

endpackage

// File: source/clk_rst_gen.sv
// clock enables and reset sync
`include "game_mem_defines.svh"

module clk_rst_gen (
    input  logic clk96,       // only clock in the design
    input  logic arst_n,
    input  logic game_rst,    // core reset request
    input  logic pll_locked,
    output logic rst96,       // synchronous to clk96
    output logic cen48,       // every 2nd cycle
    output logic cen24,       // every 4th cycle
    output logic cen6         // every 16th cycle
);

    logic [`GM_RST_STAGES-1:0] sync_q;     // ones shift in once all sources are good
    logic [`GM_RST_STAGES-1:0] sync_nxt;
    logic [3:0]                cnt;        // free-running divider
    logic [3:0]                cnt_nxt;
    logic                      run_nxt;    // out of reset next cycle

    always_comb begin
        if (game_rst || !pll_locked) begin
            sync_nxt = '0;                                    // restart the stretch
        end else begin
            sync_nxt = {sync_q[`GM_RST_STAGES-2:0], 1'b1};
        end
        run_nxt = sync_nxt[`GM_RST_STAGES-1];
        cnt_nxt = run_nxt ? cnt + 4'd1 : 4'd0;                // held at zero in reset
    end

    // cen decoded from the next count so they line up with cnt
    // and drop together with rst96
    always_ff @(posedge clk96 or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= '0;
            cnt    <= 4'd0;
            cen48  <= 1'b0;
            cen24  <= 1'b0;
            cen6   <= 1'b0;
        end else begin
            sync_q <= sync_nxt;
            cnt    <= cnt_nxt;
            cen48  <= cnt_nxt[0];
            cen24  <= &cnt_nxt[1:0];
            cen6   <= &cnt_nxt;          // all three meet at the wrap
        end
    end

    assign rst96 = ~sync_q[`GM_RST_STAGES-1];   // released after the last stage fills

endmodule

// File: source/rom_slot.sv
// cached rom read slot
`include "game_mem_defines.svh"

module rom_slot #(
    parameter game_mem_pkg::port_id_e SLOT_ID = game_mem_pkg::ID_CPU
) (
    input  logic                   clk96,
    input  logic                   arst_n,
    input  logic                   rst,
    input  logic                   cs,      // level from the core
    input  logic [`GM_AW-1:0]      addr,
    input  logic                   flush,   // download in progress
    input  logic                   gnt,     // one cycle pulse from the arbiter
    input  game_mem_pkg::rom_rsp_t rsp,     // shared by all slots
    output logic [`GM_DW-1:0]      dout,
    output logic                   ok,
    output game_mem_pkg::rom_req_t req
);
    import game_mem_pkg::*;

    slot_state_e       state;
    logic              cache_vld;
    logic              stale_q;      // a flush hit the fetch in flight
    logic [`GM_AW-1:0] cache_addr;   // also the fetch address while busy
    logic [`GM_DW-1:0] cache_data;
    logic              hit;
    logic              miss;
    logic              rsp_mine;

    always_comb begin
        hit       = cache_vld && (cache_addr == addr);
        miss      = cs && !hit;
        rsp_mine  = rsp.valid && (rsp.id == SLOT_ID);   // ignore the other slot's data
        ok        = cs && hit;
        dout      = cache_data;
        req.valid = (state == SLOT_REQ);                // held until gnt
        req.addr  = cache_addr;
        req.id    = SLOT_ID;
    end

    always_ff @(posedge clk96 or negedge arst_n) begin
        if (!arst_n) begin
            state     <= SLOT_IDLE;
            cache_vld <= 1'b0;
            stale_q   <= 1'b0;
        end else if (rst) begin
            state     <= SLOT_IDLE;
            cache_vld <= 1'b0;
            stale_q   <= 1'b0;
        end else begin
            case (state)
                SLOT_IDLE: begin
                    if (miss) begin
                        state     <= SLOT_REQ;
                        cache_vld <= 1'b0;   // entry is being replaced
                    end
                end
                SLOT_REQ: begin
                    if (gnt) state <= SLOT_WAIT;
                end
                SLOT_WAIT: begin
                    if (rsp_mine) begin
                        state     <= SLOT_IDLE;
                        cache_vld <= !stale_q;   // stale data is dropped, refetched from idle
                    end
                end
                default: state <= SLOT_IDLE;
            endcase
            if (flush) cache_vld <= 1'b0;   // overrides a response in the same cycle
            stale_q <= (state == SLOT_WAIT) && !rsp_mine && (stale_q || flush);
        end
    end

    // payload, no reset needed
    always_ff @(posedge clk96) begin
        if (state == SLOT_IDLE && miss) cache_addr <= addr;      // address to fetch
        if (state == SLOT_WAIT && rsp_mine) cache_data <= rsp.data;
    end

endmodule

// File: source/rom_arbiter.sv
// shared rom bus arbiter
`include "game_mem_defines.svh"

module rom_arbiter (
    input  logic                   clk96,
    input  logic                   arst_n,
    input  logic                   rst,
    input  logic                   downloading,   // loader has absolute priority
    input  logic                   dwn_we,
    input  logic [`GM_AW-1:0]      dwn_addr,
    input  logic [`GM_DW-1:0]      dwn_data,
    input  game_mem_pkg::rom_req_t cpu_req,
    input  game_mem_pkg::rom_req_t vid_req,
    input  game_mem_pkg::rom_rsp_t rsp_in,        // only the strobe matters here
    output logic                   cpu_gnt,
    output logic                   vid_gnt,
    output game_mem_pkg::rom_req_t mem_req,
    output logic                   mem_we,
    output logic [`GM_AW-1:0]      mem_waddr,
    output logic [`GM_DW-1:0]      mem_wdata,
    output logic                   flush          // to both slots
);
    import game_mem_pkg::*;

    arb_state_e state;
    arb_state_e state_nxt;
    logic       vid_lost_q;   // video lost the last conflict
    logic       can_grant;
    logic       conflict;
    logic       pick_vid;

    always_comb begin
        can_grant = (state == ARB_IDLE) && !downloading;
        conflict  = cpu_req.valid && vid_req.valid;
        pick_vid  = vid_req.valid && (!cpu_req.valid || vid_lost_q);   // cpu first by default
        cpu_gnt   = can_grant && cpu_req.valid && !pick_vid;
        vid_gnt   = can_grant && pick_vid;
        mem_req       = pick_vid ? vid_req : cpu_req;   // id rides along from the slot
        mem_req.valid = cpu_gnt || vid_gnt;
    end

    // loader writes go straight to the store
    always_comb begin
        mem_we    = downloading && dwn_we;
        mem_waddr = dwn_addr;
        mem_wdata = dwn_data;
        flush     = downloading || (state == ARB_LOAD);   // one extra cycle after the last write
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ARB_IDLE: begin
                if (downloading) begin
                    state_nxt = ARB_LOAD;
                end else if (cpu_gnt || vid_gnt) begin
                    state_nxt = ARB_WAIT;
                end
            end
            ARB_WAIT: begin
                // the read in flight must finish before the loader takes over
                if (rsp_in.valid) state_nxt = downloading ? ARB_LOAD : ARB_IDLE;
            end
            ARB_LOAD: begin
                if (!downloading) state_nxt = ARB_IDLE;
            end
            default: state_nxt = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk96 or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ARB_IDLE;
            vid_lost_q <= 1'b0;
        end else if (rst) begin
            state      <= ARB_IDLE;
            vid_lost_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (can_grant && conflict) vid_lost_q <= !pick_vid;   // alternate under contention
        end
    end

endmodule

// File: source/rom_store.sv
// latency-modelled rom store
`include "game_mem_defines.svh"

module rom_store (
    input  logic                   clk96,
    input  logic                   arst_n,
    input  logic                   rst,
    input  game_mem_pkg::rom_req_t req,     // at most one read in flight
    input  logic                   we,      // download write port
    input  logic [`GM_AW-1:0]      waddr,
    input  logic [`GM_DW-1:0]      wdata,
    output game_mem_pkg::rom_rsp_t rsp
);
    import game_mem_pkg::*;

    logic [`GM_DW-1:0]      mem [`GM_DEPTH];
    logic                   req_vld_q;            // command register, like an sdram activate
    logic [`GM_AW-1:0]      req_addr_q;
    port_id_e               req_id_q;
    logic [`GM_MEM_LAT-1:0] vld_q;                // delay line strobes
    port_id_e               id_q   [`GM_MEM_LAT];
    logic [`GM_DW-1:0]      data_q [`GM_MEM_LAT];

    always_ff @(posedge clk96) begin
        if (we) begin
            mem[waddr] <= wdata;   // visible on the next cycle
        end
    end

    always_ff @(posedge clk96 or negedge arst_n) begin
        if (!arst_n) begin
            req_vld_q <= 1'b0;
            vld_q     <= '0;
        end else if (rst) begin
            req_vld_q <= 1'b0;     // drop a read cut off by a game reset
            vld_q     <= '0;
        end else begin
            req_vld_q <= req.valid;
            vld_q     <= {vld_q[`GM_MEM_LAT-2:0], req_vld_q};
        end
    end

    // data path of the delay line
    always_ff @(posedge clk96) begin
        req_addr_q <= req.addr;
        req_id_q   <= req.id;
        id_q[0]    <= req_id_q;
        data_q[0]  <= mem[req_addr_q];
        for (int i = 1; i < `GM_MEM_LAT; i++) begin
            id_q[i]   <= id_q[i-1];
            data_q[i] <= data_q[i-1];
        end
    end

    always_comb begin
        rsp.valid = vld_q[`GM_MEM_LAT-1];   // GM_MEM_LAT edges after the request is taken
        rsp.id    = id_q[`GM_MEM_LAT-1];
        rsp.data  = data_q[`GM_MEM_LAT-1];
    end

endmodule

// File: source/game_mem_top.sv
// game memory subsystem
`include "game_mem_defines.svh"

module game_mem_top (
    input  logic              clk96,
    input  logic              arst_n,
    input  logic              game_rst,
    input  logic              pll_locked,
    input  logic              downloading,
    input  logic              dwn_we,
    input  logic [`GM_AW-1:0] dwn_addr,
    input  logic [`GM_DW-1:0] dwn_data,
    input  logic              cpu_cs,
    input  logic [`GM_AW-1:0] cpu_addr,
    input  logic              vid_cs,
    input  logic [`GM_AW-1:0] vid_addr,
    output logic              rst96,
    output logic              cen48,
    output logic              cen24,
    output logic              cen6,
    output logic [`GM_DW-1:0] cpu_dout,
    output logic              cpu_ok,
    output logic [`GM_DW-1:0] vid_dout,
    output logic              vid_ok
);
    import game_mem_pkg::*;

    rom_req_t          cpu_req;
    rom_req_t          vid_req;
    rom_req_t          mem_req;     // granted read
    rom_rsp_t          mem_rsp;     // fanned out to both slots
    logic              cpu_gnt;
    logic              vid_gnt;
    logic              flush;
    logic              mem_we;
    logic [`GM_AW-1:0] mem_waddr;
    logic [`GM_DW-1:0] mem_wdata;

    clk_rst_gen u_clk_rst (
        .clk96(clk96), .arst_n(arst_n), .game_rst(game_rst), .pll_locked(pll_locked),
        .rst96(rst96), .cen48(cen48), .cen24(cen24), .cen6(cen6)
    );

    rom_slot #(.SLOT_ID(ID_CPU)) u_cpu_slot (
        .clk96(clk96), .arst_n(arst_n), .rst(rst96), .cs(cpu_cs), .addr(cpu_addr),
        .flush(flush), .gnt(cpu_gnt), .rsp(mem_rsp),
        .dout(cpu_dout), .ok(cpu_ok), .req(cpu_req)
    );

    rom_slot #(.SLOT_ID(ID_VID)) u_vid_slot (
        .clk96(clk96), .arst_n(arst_n), .rst(rst96), .cs(vid_cs), .addr(vid_addr),
        .flush(flush), .gnt(vid_gnt), .rsp(mem_rsp),
        .dout(vid_dout), .ok(vid_ok), .req(vid_req)
    );

    rom_arbiter u_arbiter (
        .clk96(clk96), .arst_n(arst_n), .rst(rst96), .downloading(downloading),
        .dwn_we(dwn_we), .dwn_addr(dwn_addr), .dwn_data(dwn_data),
        .cpu_req(cpu_req), .vid_req(vid_req), .rsp_in(mem_rsp),
        .cpu_gnt(cpu_gnt), .vid_gnt(vid_gnt), .mem_req(mem_req),
        .mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata), .flush(flush)
    );

    rom_store u_store (
        .clk96(clk96), .arst_n(arst_n), .rst(rst96), .req(mem_req),
        .we(mem_we), .waddr(mem_waddr), .wdata(mem_wdata), .rsp(mem_rsp)
    );

endmodule

// File: tests/game_mem_tb.sv
// game memory testbench
`include "game_mem_defines.svh"

module game_mem_tb;

    localparam int OK_TIMEOUT  = 64;   // cycles allowed for any read
    localparam int RST_TIMEOUT = 16;   // cycles allowed for reset release

    logic              clk96;
    logic              arst_n;
    logic              game_rst;
    logic              pll_locked;
    logic              downloading;
    logic              dwn_we;
    logic [`GM_AW-1:0] dwn_addr;
    logic [`GM_DW-1:0] dwn_data;
    logic              cpu_cs;
    logic [`GM_AW-1:0] cpu_addr;
    logic              vid_cs;
    logic [`GM_AW-1:0] vid_addr;
    logic              rst96;
    logic              cen48;
    logic              cen24;
    logic              cen6;
    logic [`GM_DW-1:0] cpu_dout;
    logic              cpu_ok;
    logic [`GM_DW-1:0] vid_dout;
    logic              vid_ok;

    logic [`GM_DW-1:0] shadow [`GM_DEPTH];   // every word the loader wrote
    logic              cpu_last_vld;         // cpu cache should hold cpu_last_addr
    logic [`GM_AW-1:0] cpu_last_addr;
    logic              vid_last_vld;
    logic [`GM_AW-1:0] vid_last_addr;
    int unsigned       seed = 32'h68e27516;  // random seed, stimulus is all from file

    game_mem_top dut (
        .clk96(clk96), .arst_n(arst_n), .game_rst(game_rst), .pll_locked(pll_locked),
        .downloading(downloading), .dwn_we(dwn_we), .dwn_addr(dwn_addr), .dwn_data(dwn_data),
        .cpu_cs(cpu_cs), .cpu_addr(cpu_addr), .vid_cs(vid_cs), .vid_addr(vid_addr),
        .rst96(rst96), .cen48(cen48), .cen24(cen24), .cen6(cen6),
        .cpu_dout(cpu_dout), .cpu_ok(cpu_ok), .vid_dout(vid_dout), .vid_ok(vid_ok)
    );

    initial begin
        clk96 = 1'b0;
        forever #10 clk96 = ~clk96;   // period 20
    end

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    // counts rising edges until rst96 drops, enables stay quiet meanwhile
    task automatic wait_release(input string src);
        int n;
        bit done;
        n = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk96);
            n++;
            if (rst96 === 1'b0) begin
                done = 1'b1;
            end else begin
                check_val({cen48, cen24, cen6}, 3'b000, "enables while rst96 high");
                if (n >= RST_TIMEOUT) stop_run({"timeout waiting for reset release after ", src});
            end
        end
        check_val(n, `GM_RST_STAGES, {"rst96 stretch after ", src});
    endtask

    // one cycle loader write, both caches get flushed
    task automatic download(input logic [`GM_AW-1:0] a, input logic [`GM_DW-1:0] d);
        downloading = 1'b1;
        dwn_we      = 1'b1;
        dwn_addr    = a;
        dwn_data    = d;
        @(negedge clk96);
        downloading  = 1'b0;
        dwn_we       = 1'b0;
        shadow[a]    = d;
        cpu_last_vld = 1'b0;
        vid_last_vld = 1'b0;
    endtask

    task automatic read_slot(input bit vid, input logic [`GM_AW-1:0] a,
                             input logic [`GM_DW-1:0] exp);
        int    n;
        bit    hit_exp;
        logic  ok_s;
        string tag;
        tag     = vid ? "vid" : "cpu";
        hit_exp = vid ? (vid_last_vld && vid_last_addr == a) : (cpu_last_vld && cpu_last_addr == a);
        check_val(shadow[a], exp, {tag, " stim value against shadow"});
        if (vid) begin
            vid_cs   = 1'b1;
            vid_addr = a;
        end else begin
            cpu_cs   = 1'b1;
            cpu_addr = a;
        end
        n    = 0;
        ok_s = 1'b0;
        while (ok_s !== 1'b1) begin
            @(negedge clk96);
            n++;
            ok_s = vid ? vid_ok : cpu_ok;
            if (ok_s !== 1'b1 && n >= OK_TIMEOUT) stop_run({"timeout waiting for ", tag, "_ok"});
        end
        check_val(vid ? vid_dout : cpu_dout, exp, {tag, " read data"});
        if (hit_exp) check_val(n, 1, {tag, " hit latency"});
        else check_val(n >= `GM_MEM_LAT + 2, 1, {tag, " miss faster than the store"});
        if (vid) begin
            vid_cs        = 1'b0;
            vid_last_vld  = 1'b1;
            vid_last_addr = a;
        end else begin
            cpu_cs        = 1'b0;
            cpu_last_vld  = 1'b1;
            cpu_last_addr = a;
        end
    endtask

    // both slots at once, the arbiter has to serve them in turn
    task automatic read_both(input logic [`GM_AW-1:0] ca, input logic [`GM_DW-1:0] ce,
                             input logic [`GM_AW-1:0] va, input logic [`GM_DW-1:0] ve);
        int n;
        bit cpu_done;
        bit vid_done;
        check_val(shadow[ca], ce, "cpu stim value against shadow");
        check_val(shadow[va], ve, "vid stim value against shadow");
        cpu_cs   = 1'b1;
        cpu_addr = ca;
        vid_cs   = 1'b1;
        vid_addr = va;
        n        = 0;
        cpu_done = 1'b0;
        vid_done = 1'b0;
        while (!(cpu_done && vid_done)) begin
            @(negedge clk96);
            n++;
            if (cpu_ok === 1'b1) begin
                check_val(cpu_dout, ce, "cpu data under contention");   // held while ok stays up
                cpu_done = 1'b1;
            end
            if (vid_ok === 1'b1) begin
                check_val(vid_dout, ve, "vid data under contention");
                vid_done = 1'b1;
            end
            if (!(cpu_done && vid_done) && n >= OK_TIMEOUT)
                stop_run("timeout waiting for both slots under contention");
        end
        cpu_cs        = 1'b0;
        vid_cs        = 1'b0;
        cpu_last_vld  = 1'b1;
        cpu_last_addr = ca;
        vid_last_vld  = 1'b1;
        vid_last_addr = va;
    endtask

    // hold cached hits, then game_rst or pll loss must kill ok
    task automatic reset_pulse(input bit pll);
        string src;
        src      = pll ? "pll lock loss" : "game reset";
        cpu_cs   = cpu_last_vld;
        cpu_addr = cpu_last_addr;
        vid_cs   = vid_last_vld;
        vid_addr = vid_last_addr;
        @(negedge clk96);
        check_val(cpu_ok, cpu_last_vld, "cpu hit before reset");
        check_val(vid_ok, vid_last_vld, "vid hit before reset");
        if (pll) pll_locked = 1'b0;
        else game_rst = 1'b1;
        // rst96 rises after one edge, the slots clear their caches on the next
        repeat (pll ? 4 : 2) @(negedge clk96);
        check_val(rst96, 1'b1, {"rst96 during ", src});
        check_val(cpu_ok, 1'b0, {"cpu_ok during ", src});
        check_val(vid_ok, 1'b0, {"vid_ok during ", src});
        cpu_cs       = 1'b0;
        vid_cs       = 1'b0;
        pll_locked   = 1'b1;
        game_rst     = 1'b0;
        cpu_last_vld = 1'b0;   // caches are invalid after any reset
        vid_last_vld = 1'b0;
        wait_release(src);
    endtask

    initial begin
        int                fd;
        int                code;
        int                n48;
        int                n24;
        int                n6;
        logic [7:0]        op;
        logic [`GM_AW-1:0] a0;
        logic [`GM_DW-1:0] d0;
        logic [`GM_AW-1:0] a1;
        logic [`GM_DW-1:0] d1;
        logic [8*128-1:0]  line;
        arst_n        = 1'b0;
        game_rst      = 1'b0;
        pll_locked    = 1'b1;
        downloading   = 1'b0;
        dwn_we        = 1'b0;
        dwn_addr      = '0;
        dwn_data      = '0;
        cpu_cs        = 1'b0;
        cpu_addr      = '0;
        vid_cs        = 1'b0;
        vid_addr      = '0;
        cpu_last_vld  = 1'b0;
        cpu_last_addr = '0;
        vid_last_vld  = 1'b0;
        vid_last_addr = '0;
        fd = $fopen("tests/game_mem_stim.txt", "r");
        if (fd == 0) stop_run("cannot open stimulus file tests/game_mem_stim.txt");
        repeat (3) @(negedge clk96);
        check_val(rst96, 1'b1, "rst96 during arst_n");
        check_val({cen48, cen24, cen6}, 3'b000, "enables during arst_n");
        arst_n = 1'b1;
        wait_release("arst_n");
        n48 = 0;
        n24 = 0;
        n6  = 0;
        for (int i = 0; i < 64; i++) begin
            n48 += cen48;
            n24 += cen24;
            n6  += cen6;
            if (cen6) check_val(cen24, 1'b1, "cen6 without cen24");
            @(negedge clk96);
        end
        check_val(n48, 32, "cen48 pulses in 64 cycles");
        check_val(n24, 16, "cen24 pulses in 64 cycles");
        check_val(n6, 4, "cen6 pulses in 64 cycles");
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", op);
            if (code == 1) begin
                case (op)
                    "#": code = $fgets(line, fd);   // comment line
                    "W", "C", "V": begin
                        code = $fscanf(fd, "%h %h", a0, d0);
                        if (code != 2) stop_run("bad operands in stimulus file");
                        if (op == "W") download(a0, d0);
                        else read_slot(op == "V", a0, d0);
                    end
                    "B": begin
                        code = $fscanf(fd, "%h %h %h %h", a0, d0, a1, d1);
                        if (code != 4) stop_run("bad operands in stimulus file");
                        read_both(a0, d0, a1, d1);
                    end
                    "R": reset_pulse(1'b0);
                    "L": reset_pulse(1'b1);
                    default: stop_run("unknown operation in stimulus file");
                endcase
            end
        end
        $fclose(fd);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: tests/game_mem_stim.txt
# ops: W addr data | C addr exp | V addr exp | B cpu_addr cpu_exp vid_addr vid_exp | R | L
# addr and data in hex, R pulses game_rst, L drops pll_locked
W 000 1234
W 001 abcd
W 002 0f0f
W 010 5a5a
W 7ff beef
W fff c0de
W 123 4567
C 000 1234
C 000 1234
V 001 abcd
V 001 abcd
C 7ff beef
V fff c0de
V 123 4567
B 002 0f0f 010 5a5a
B 010 5a5a 002 0f0f
B 123 4567 123 4567
B 000 1234 001 abcd
# rewrite a word that both caches hold
C 002 0f0f
V 002 0f0f
W 002 7777
C 002 7777
V 002 7777
C 002 7777
R
C 002 7777
V 010 5a5a
L
C 000 1234
V fff c0de
C fff c0de
B 7ff beef 000 1234

// File: files.f
+incdir+source
source/game_mem_pkg.sv
source/clk_rst_gen.sv
source/rom_slot.sv
source/rom_arbiter.sv
source/rom_store.sv
source/game_mem_top.sv
tests/game_mem_tb.sv

// File: Bender.yml
package:
  name: game_mem

sources:
  - include_dirs:
      - source
    files:
      - source/game_mem_pkg.sv
      - source/clk_rst_gen.sv
      - source/rom_slot.sv
      - source/rom_arbiter.sv
      - source/rom_store.sv
      - source/game_mem_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/game_mem_tb.sv
